// ==== source/mod_pkg.sv ====
package mod_pkg;

  // ----------------------------------------------------------
  // sizes
  // ----------------------------------------------------------

  // external mode toggles between exactly two segments.
  localparam int num_segment = 2;
  localparam int idx_w = 15;

  // repeat value that means loop forever.
  localparam logic [31:0] rep_infinite = 32'hffff_ffff;

  // ----------------------------------------------------------
  // transition modes
  // ----------------------------------------------------------

  typedef logic [7:0] trans_mode_t;

  localparam trans_mode_t mode_sync_idx = 8'h00;
  localparam trans_mode_t mode_sys_time = 8'h01;
  localparam trans_mode_t mode_gpio = 8'h02;
  localparam trans_mode_t mode_ext = 8'hf0;

  // divisor for the lap computation, one sync period in time units.
  localparam logic [63:0] sync_base = 64'd500000;

  // pipeline depth of the transition timer.
  localparam int time_latency = 3;

  // ----------------------------------------------------------
  // configuration
  // ----------------------------------------------------------

  typedef logic [idx_w-1:0] idx_t;

  typedef struct packed {
    idx_t        cycle;
    logic [31:0] rep;
    logic [15:0] freq_div;
  } seg_cfg_t;

  // gpio mode keeps the pin number in value[1:0].
  typedef struct packed {
    trans_mode_t mode;
    logic [63:0] value;
  } transition_t;

endpackage

// ==== source/segment_timer.sv ====
`timescale 1ns/1ps
module segment_timer
  import mod_pkg::*;
(
  input  logic     CLK,
  input  logic     rst,
  input  seg_cfg_t cfg,
  output idx_t     sync_idx
);

  logic [15:0] div_cnt;
  logic [15:0] div_last;
  logic        step;

  // ----------------------------------------------------------
  // rate divider
  // ----------------------------------------------------------

  // a zero divider behaves like one, the index steps every clock.
  assign div_last = (cfg.freq_div == 16'd0) ? 16'd0 : cfg.freq_div - 16'd1;
  assign step = (div_cnt >= div_last);

  always_ff @(posedge CLK) begin
    if (rst) begin
      div_cnt <= '0;
    end else if (step) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 16'd1;
    end
  end

  // ----------------------------------------------------------
  // index counter
  // ----------------------------------------------------------

  always_ff @(posedge CLK) begin
    if (rst) begin
      sync_idx <= '0;
    end else if (step) begin
      // wrap at the last index of the cycle.
      if (sync_idx >= cfg.cycle) begin
        sync_idx <= '0;
      end else begin
        sync_idx <= sync_idx + 1'b1;
      end
    end
  end

endmodule

// ==== source/transition_timer.sv ====
`timescale 1ns/1ps
module transition_timer
  import mod_pkg::*;
(
  input  logic        CLK,
  input  logic        rst,
  input  logic [63:0] sys_time,
  input  logic [17:0] sync_base_cnt,
  input  logic [63:0] trans_value,
  output logic        time_reached
);

  logic [63:0] lap;
  logic [17:0] base_cnt_q;
  logic [63:0] time_q1;
  logic [63:0] lap_time;
  logic [63:0] time_q2;

  // ----------------------------------------------------------
  // stage 1
  // ----------------------------------------------------------

  // round the request down to whole sync periods.
  always_ff @(posedge CLK) begin
    lap <= trans_value / sync_base;
    base_cnt_q <= sync_base_cnt;
    time_q1 <= sys_time;
  end

  // ----------------------------------------------------------
  // stage 2
  // ----------------------------------------------------------

  // scale the lap count back into system time units.
  always_ff @(posedge CLK) begin
    lap_time <= lap * 64'(base_cnt_q);
    time_q2 <= time_q1;
  end

  // ----------------------------------------------------------
  // stage 3
  // ----------------------------------------------------------

  // sys_time travels with the lap so all inputs share one sample point.
  always_ff @(posedge CLK) begin
    if (rst) begin
      time_reached <= 1'b0;
    end else begin
      time_reached <= (lap_time < time_q2);
    end
  end

endmodule

// ==== source/mod_swapchain.sv ====
`timescale 1ns/1ps
module mod_swapchain
  import mod_pkg::*;
(
  input  logic                       CLK,
  input  logic                       rst,
  input  logic                       update_settings,
  input  logic                       req_segment,
  input  transition_t                transition,
  input  seg_cfg_t [num_segment-1:0] seg_cfg,
  input  idx_t [num_segment-1:0]     sync_idx,
  input  logic                       time_reached,
  input  logic [3:0]                 gpio_in,
  output logic                       stop,
  output logic                       segment,
  output idx_t [num_segment-1:0]     idx
);

  typedef enum logic [1:0] {
    st_wait_start,
    st_finite_loop,
    st_infinite_loop
  } state_t;

  typedef enum logic {
    idx_mode_sync,
    idx_mode_tick
  } idx_mode_t;

  state_t                          state;
  idx_mode_t                       idx_mode;
  logic                            ext_mode;
  logic [31:0]                     rep_q;
  logic [31:0]                     loop_cnt;
  logic                            pend_segment;
  logic [$clog2(time_latency+1)-1:0] lat_cnt;

  idx_t [num_segment-1:0] idx_old;
  idx_t [num_segment-1:0] tick_idx;
  logic [num_segment-1:0] idx_changed;
  logic [num_segment-1:0] wrapped;

  // ----------------------------------------------------------
  // index change detection and output mux
  // ----------------------------------------------------------

  for (genvar i = 0; i < num_segment; i++) begin : gen_idx
    assign idx_changed[i] = (idx_old[i] != sync_idx[i]);
    assign wrapped[i] = idx_changed[i] && (sync_idx[i] == '0);
    assign idx[i] = (idx_mode == idx_mode_sync) ? idx_old[i] : tick_idx[i];
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      idx_old <= '0;
    end else begin
      idx_old <= sync_idx;
    end
  end

  // ----------------------------------------------------------
  // segment FSM
  // ----------------------------------------------------------

  always_ff @(posedge CLK) begin
    if (rst) begin
      segment <= 1'b0;
      stop <= 1'b0;
      state <= st_infinite_loop;
      idx_mode <= idx_mode_sync;
      ext_mode <= 1'b0;
      loop_cnt <= '0;
      lat_cnt <= '0;
      tick_idx <= '0;
    end else if (update_settings) begin
      if ((req_segment == segment) || (seg_cfg[req_segment].rep == rep_infinite)) begin
        // no transition to wait for, loop forever right away.
        stop <= 1'b0;
        segment <= req_segment;
        idx_mode <= idx_mode_sync;
        ext_mode <= (transition.mode == mode_ext);
        state <= st_infinite_loop;
      end else begin
        rep_q <= seg_cfg[req_segment].rep;
        pend_segment <= req_segment;
        lat_cnt <= '0;
        state <= st_wait_start;
      end
    end else begin
      case (state)
        st_wait_start: begin
          case (transition.mode)
            mode_sync_idx: begin
              if (wrapped[pend_segment]) begin
                stop <= 1'b0;
                loop_cnt <= '0;
                segment <= pend_segment;
                idx_mode <= idx_mode_sync;
                state <= st_finite_loop;
              end
            end
            mode_sys_time: begin
              // time_reached lags the strobe by the timer pipeline.
              if (lat_cnt == time_latency - 1) begin
                if (time_reached) begin
                  stop <= 1'b0;
                  loop_cnt <= '0;
                  segment <= pend_segment;
                  idx_mode <= idx_mode_tick;
                  tick_idx[pend_segment] <= '0;
                  state <= st_finite_loop;
                end
              end else begin
                lat_cnt <= lat_cnt + 1'b1;
              end
            end
            mode_gpio: begin
              if (idx_changed[pend_segment] && gpio_in[transition.value[1:0]]) begin
                stop <= 1'b0;
                loop_cnt <= '0;
                segment <= pend_segment;
                idx_mode <= idx_mode_tick;
                tick_idx[pend_segment] <= '0;
                state <= st_finite_loop;
              end
            end
            default: ;
          endcase
        end
        st_infinite_loop: begin
          if (ext_mode && wrapped[segment]) begin
            segment <= ~segment;
          end
        end
        st_finite_loop: begin
          if (idx_mode == idx_mode_sync) begin
            if (wrapped[segment]) begin
              if (loop_cnt == rep_q) begin
                stop <= 1'b1;
              end else begin
                loop_cnt <= loop_cnt + 32'd1;
              end
            end
          end else if (idx_changed[segment]) begin
            // own tick index, counts one per sync index change.
            if (tick_idx[segment] >= seg_cfg[segment].cycle) begin
              tick_idx[segment] <= '0;
              if (loop_cnt == rep_q) begin
                stop <= 1'b1;
              end else begin
                loop_cnt <= loop_cnt + 32'd1;
              end
            end else begin
              tick_idx[segment] <= tick_idx[segment] + 1'b1;
            end
          end
        end
        default: begin
          state <= st_infinite_loop;
        end
      endcase
    end
  end

endmodule

// ==== source/mod_subsystem.sv ====
`timescale 1ns/1ps
module mod_subsystem
  import mod_pkg::*;
(
  input  logic                       CLK,
  input  logic                       rst,
  input  logic [63:0]                sys_time,
  input  logic [17:0]                sync_base_cnt,
  input  seg_cfg_t [num_segment-1:0] seg_cfg,
  input  transition_t                transition,
  input  logic                       req_segment,
  input  logic                       update_settings,
  input  logic [3:0]                 gpio_in,
  output logic                       segment,
  output logic                       stop,
  output idx_t [num_segment-1:0]     idx
);

  idx_t [num_segment-1:0] sync_idx;
  logic                   time_reached;

  // ----------------------------------------------------------
  // per segment sample index
  // ----------------------------------------------------------

  for (genvar i = 0; i < num_segment; i++) begin : gen_seg_timer
    segment_timer u_segment_timer (
      .CLK      (CLK),
      .rst      (rst),
      .cfg      (seg_cfg[i]),
      .sync_idx (sync_idx[i])
    );
  end

  transition_timer u_transition_timer (
    .CLK           (CLK),
    .rst           (rst),
    .sys_time      (sys_time),
    .sync_base_cnt (sync_base_cnt),
    .trans_value   (transition.value),
    .time_reached  (time_reached)
  );

  // ----------------------------------------------------------
  // swap controller
  // ----------------------------------------------------------

  mod_swapchain u_mod_swapchain (
    .CLK             (CLK),
    .rst             (rst),
    .update_settings (update_settings),
    .req_segment     (req_segment),
    .transition      (transition),
    .seg_cfg         (seg_cfg),
    .sync_idx        (sync_idx),
    .time_reached    (time_reached),
    .gpio_in         (gpio_in),
    .stop            (stop),
    .segment         (segment),
    .idx             (idx)
  );

endmodule

// ==== verif/mod_asserts.sv ====
`timescale 1ns/1ps
module mod_asserts
  import mod_pkg::*;
(
  input logic                       CLK,
  input logic                       rst,
  input logic                       update_settings,
  input logic                       time_reached,
  input logic [1:0]                 state,
  input logic                       stop,
  input logic                       segment,
  input logic [num_segment-1:0]     idx_changed,
  input seg_cfg_t [num_segment-1:0] seg_cfg,
  input idx_t [num_segment-1:0]     tick_idx
);

  // encoding of the infinite loop state in the swap FSM.
  localparam logic [1:0] state_infinite = 2'd2;

  int unsigned fail_cnt = 0;

  stop_rise: assert property (@(posedge CLK) disable iff (rst)
    $rose(stop) |-> (state != state_infinite))
    else begin
      $error("stop rose in the infinite loop state");
      fail_cnt++;
    end

  // a system time switch follows the timer pipeline, not an index change.
  seg_change: assert property (@(posedge CLK) disable iff (rst)
    $changed(segment) |-> ($past(update_settings) || $past(|idx_changed) || $past(time_reached)))
    else begin
      $error("segment changed without update or index change");
      fail_cnt++;
    end

  for (genvar i = 0; i < num_segment; i++) begin : gen_tick
    tick_range: assert property (@(posedge CLK) disable iff (rst)
      tick_idx[i] <= seg_cfg[i].cycle)
      else begin
        $error("tick index above cycle on segment %0d", i);
        fail_cnt++;
      end
  end

endmodule

bind mod_swapchain mod_asserts swap_chk (
  .CLK             (CLK),
  .rst             (rst),
  .update_settings (update_settings),
  .time_reached    (time_reached),
  .state           (state),
  .stop            (stop),
  .segment         (segment),
  .idx_changed     (idx_changed),
  .seg_cfg         (seg_cfg),
  .tick_idx        (tick_idx)
);

// ==== verif/tb_mod_subsystem.sv ====
`timescale 1ns/1ps
module tb_mod_subsystem
  import mod_pkg::*;
();

  logic                       CLK;
  logic                       rst;
  logic [63:0]                sys_time;
  logic [17:0]                sync_base_cnt;
  seg_cfg_t [num_segment-1:0] seg_cfg;
  transition_t                transition;
  logic                       req_segment;
  logic                       update_settings;
  logic [3:0]                 gpio_in;
  logic                       segment;
  logic                       stop;
  idx_t [num_segment-1:0]     idx;

  // model of both segment timers and the controller's delayed index.
  logic [15:0] m_div [num_segment];
  idx_t        m_idx [num_segment];
  idx_t        m_old [num_segment];
  int          wrap_cnt [num_segment];
  int          chg_cnt [num_segment];
  idx_t        m_tick;
  logic        tick_on;
  logic        tick_seg;
  logic        check_idx;
  logic [31:0] lfsr;

  mod_subsystem uut (
    .CLK             (CLK),
    .rst             (rst),
    .sys_time        (sys_time),
    .sync_base_cnt   (sync_base_cnt),
    .seg_cfg         (seg_cfg),
    .transition      (transition),
    .req_segment     (req_segment),
    .update_settings (update_settings),
    .gpio_in         (gpio_in),
    .segment         (segment),
    .stop            (stop),
    .idx             (idx)
  );

  always #20 CLK = ~CLK;

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------

  // galois form of x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // next {divider, index} of one segment timer.
  function automatic logic [16+idx_w-1:0] timer_next(input seg_cfg_t cfg,
                                                     input logic [15:0] div, input idx_t ix);
    logic [15:0] nd;
    idx_t        ni;
    nd = div + 16'd1;
    ni = ix;
    if (nd == cfg.freq_div) begin
      nd = '0;
      ni = (ix == cfg.cycle) ? '0 : ix + 1'b1;
    end
    return {nd, ni};
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic wait_step(inout int count, input int limit, input string what);
    @(negedge CLK);
    count++;
    if (count > limit) begin
      $display("timed out waiting for %s", what);
      $display("TESTBENCH FAILED");
      $fatal(1, "wait timeout");
    end
  endtask

  task automatic hold_outputs(input int cycles, input logic seg, input logic stp);
    repeat (cycles) begin
      check_value("segment", segment, seg);
      check_value("stop", stop, stp);
      @(negedge CLK);
    end
  endtask

  // one-cycle update strobe that starts on a falling edge.
  task automatic send_update(input logic req, input trans_mode_t mode,
                             input logic [63:0] value);
    req_segment = req;
    transition.mode = mode;
    transition.value = value;
    update_settings = 1'b1;
    @(negedge CLK);
    update_settings = 1'b0;
  endtask

  // ------------------------------------------------------------
  // reference model and compare
  // ------------------------------------------------------------

  always @(posedge CLK) begin
    for (int i = 0; i < num_segment; i++) begin
      if (rst) begin
        m_div[i] = '0;
        m_idx[i] = '0;
        m_old[i] = '0;
      end else begin
        if (m_old[i] != m_idx[i]) begin
          chg_cnt[i]++;
          if (m_idx[i] == '0) begin
            wrap_cnt[i]++;
          end
          if (tick_on && (tick_seg == i)) begin
            m_tick = (m_tick == seg_cfg[i].cycle) ? '0 : m_tick + 1'b1;
          end
        end
        m_old[i] = m_idx[i];
        {m_div[i], m_idx[i]} = timer_next(seg_cfg[i], m_div[i], m_idx[i]);
      end
    end
  end

  always @(negedge CLK) begin
    if (!rst) begin
      if (check_idx) begin
        check_value("idx[0]", idx[0], m_old[0]);
        check_value("idx[1]", idx[1], m_old[1]);
      end
      if (tick_on) begin
        check_value($sformatf("idx[%0d]", tick_seg), idx[tick_seg], m_tick);
      end
      if (uut.u_mod_swapchain.swap_chk.fail_cnt != 0) begin
        $display("a concurrent assertion failed in the swap controller");
        $display("TESTBENCH FAILED");
        $fatal(1, "assertion failure");
      end
    end
  end

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------

  initial begin
    logic [31:0] v;
    logic [31:0] rep_saved [num_segment];
    logic [63:0] trans_val;
    logic [63:0] lap_time;
    logic        exp_seg;
    int          base;
    int          waited;
    int          toggles;
    CLK = 1'b0;
    rst = 1'b1;
    sys_time = '0;
    sync_base_cnt = 18'd1000;
    transition = '0;
    req_segment = 1'b0;
    update_settings = 1'b0;
    gpio_in = 4'h0;
    check_idx = 1'b0;
    tick_on = 1'b0;
    tick_seg = 1'b0;
    m_tick = '0;
    lfsr = 32'hcc3c;
    for (int i = 0; i < num_segment; i++) begin
      wrap_cnt[i] = 0;
      chg_cnt[i] = 0;
      draw_bits(3, v);
      seg_cfg[i].cycle = idx_t'(v + 32'd3);
      draw_bits(2, v);
      seg_cfg[i].freq_div = 16'(v + 32'd1);
      draw_bits(2, v);
      seg_cfg[i].rep = v;
      rep_saved[i] = v;
    end
    repeat (16) @(negedge CLK);
    rst = 1'b0;
    check_idx = 1'b1;
    hold_outputs(60, 1'b0, 1'b0);

    // sync index transition to segment 1 with finite loops.
    send_update(1'b1, mode_sync_idx, 64'd0);
    base = wrap_cnt[1];
    waited = 0;
    while (wrap_cnt[1] == base) begin
      check_value("segment", segment, 1'b0);
      wait_step(waited, 120, "segment 1 index wrap");
    end
    check_value("segment", segment, 1'b1);
    base = wrap_cnt[1];
    waited = 0;
    while (wrap_cnt[1] != base + int'(rep_saved[1]) + 1) begin
      check_value("stop", stop, 1'b0);
      wait_step(waited, 250, "end of finite playback");
    end
    hold_outputs(30, 1'b1, 1'b1);

    // infinite request switches at once.
    seg_cfg[0].rep = rep_infinite;
    send_update(1'b0, mode_sync_idx, 64'd0);
    base = wrap_cnt[0];
    waited = 0;
    while (wrap_cnt[0] < base + 3) begin
      check_value("segment", segment, 1'b0);
      check_value("stop", stop, 1'b0);
      wait_step(waited, 200, "three segment 0 wraps");
    end

    // system time transition.
    trans_val = 64'd3 * sync_base + 64'd1234;
    lap_time = (trans_val / sync_base) * 64'(sync_base_cnt);
    sys_time = lap_time - 64'd100;
    check_idx = 1'b0;
    send_update(1'b1, mode_sys_time, trans_val);
    hold_outputs(20, 1'b0, 1'b0);
    sys_time = lap_time;
    hold_outputs(10, 1'b0, 1'b0);
    sys_time = lap_time + 64'd1;
    waited = 0;
    while (segment != 1'b1) begin
      wait_step(waited, time_latency + 4, "system time switch");
    end
    m_tick = '0;
    tick_seg = 1'b1;
    tick_on = 1'b1;
    base = chg_cnt[1];
    waited = 0;
    while (chg_cnt[1] < base + 2 * (int'(seg_cfg[1].cycle) + 1) + 1) begin
      wait_step(waited, 200, "tick index run on segment 1");
    end

    // gpio transition on pin 2 while the other pins stay high.
    tick_on = 1'b0;
    seg_cfg[0].rep = rep_saved[0];
    gpio_in = 4'b1011;
    send_update(1'b0, mode_gpio, 64'd2);
    base = chg_cnt[0];
    waited = 0;
    while (chg_cnt[0] < base + 3) begin
      check_value("segment", segment, 1'b1);
      wait_step(waited, 40, "segment 0 index changes");
    end
    gpio_in = 4'b1111;
    base = chg_cnt[0];
    waited = 0;
    while (chg_cnt[0] == base) begin
      check_value("segment", segment, 1'b1);
      wait_step(waited, 10, "segment 0 index change with pin high");
    end
    check_value("segment", segment, 1'b0);
    m_tick = '0;
    tick_seg = 1'b0;
    tick_on = 1'b1;
    base = chg_cnt[0];
    waited = 0;
    while (chg_cnt[0] < base + 2 * (int'(seg_cfg[0].cycle) + 1) + 1) begin
      wait_step(waited, 200, "tick index run on segment 0");
    end

    // external mode alternates forever.
    tick_on = 1'b0;
    send_update(1'b0, mode_ext, 64'd0);
    check_idx = 1'b1;
    exp_seg = 1'b0;
    base = wrap_cnt[0];
    toggles = 0;
    waited = 0;
    while (toggles < 4) begin
      if (wrap_cnt[exp_seg] != base) begin
        exp_seg = ~exp_seg;
        base = wrap_cnt[exp_seg];
        toggles++;
      end
      check_value("segment", segment, exp_seg);
      check_value("stop", stop, 1'b0);
      wait_step(waited, 300, "external mode toggles");
    end

    if (uut.u_mod_swapchain.swap_chk.fail_cnt != 0) begin
      $display("%0d concurrent assertion failures", uut.u_mod_swapchain.swap_chk.fail_cnt);
      $display("TESTBENCH FAILED");
      $fatal(1, "assertion failures");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

// ==== tb.f ====
source/mod_pkg.sv
source/segment_timer.sv
source/transition_timer.sv
source/mod_swapchain.sv
source/mod_subsystem.sv
verif/mod_asserts.sv
verif/tb_mod_subsystem.sv

// ==== Bender.yml ====
package:
  name: mod_subsystem

sources:
  # rtl, package first.
  - files:
      - source/mod_pkg.sv
      - source/segment_timer.sv
      - source/transition_timer.sv
      - source/mod_swapchain.sv
      - source/mod_subsystem.sv

  # testbench and bound assertions.
  - target: verif
    files:
      - verif/mod_asserts.sv
      - verif/tb_mod_subsystem.sv
